// ==== filelist.f ====
design/clock_pkg.sv
design/clock_ctrl_if.sv
design/tick_gen.sv
design/mode_ctrl.sv
design/hms_counter.sv
design/timekeeper.sv
design/display_scan.sv
design/clock_top.sv
dv/clock_props.sv
dv/clock_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the clock testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module clock_tb -f filelist.f \
	-o clock_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/clock_sim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log

grep -q "test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "test passed" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"

// ==== dv/clock_tb.sv ====
/*
 * Testbench for the six-digit clock with a reference display model checked on every digit.
 * Walks through reset, running time, setup, rollover and alarm with button presses.
 */
`timescale 1ns/1ps

module clock_tb import clock_pkg::*; ();

	localparam int BTN_HOLD    = 4 * BTN_SAMPLE_DIV;
	localparam int PRESS_CYC   = 2 * BTN_HOLD;
	localparam int MAX_PRESSES = 625;
	localparam int RUN_SECS    = 60;
	localparam int CYCLE_LIMIT = 2 * (MAX_PRESSES * PRESS_CYC + RUN_SECS * SEC_TICK_DIV);
	localparam int BTN_MODE    = 0;
	localparam int BTN_POS     = 1;
	localparam int BTN_INC     = 2;
	localparam int BTN_ALARM   = 3;
	localparam seg_t DIGIT_SEG [10] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33,
		7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h73};

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  btn_mode;
	logic                  btn_pos;
	logic                  btn_inc;
	logic                  btn_alarm;
	seg_t                  seg;
	logic                  seg_dp;
	logic [NUM_DIGITS-1:0] seg_enb;
	logic                  alarm;

	// Reference model state
	int          cyc = 0;
	int          total_cyc = 0;
	int          base_tick;
	int          prev_k = NUM_DIGITS - 1;
	hms_t        base_time;
	hms_t        alarm_m;
	logic        frozen;
	logic        check_en;
	mode_t       mode_m;
	pos_t        pos_m;
	int unsigned lcg_state;

	clock_top i_clock_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn_mode),
		.i_btn_pos   (btn_pos),
		.i_btn_inc   (btn_inc),
		.i_btn_alarm (btn_alarm),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	always #2 clk = ~clk;

	// Edge count since reset release and the run limit
	always @(posedge clk) begin
		total_cyc <= total_cyc + 1;
		if (rst_n) begin
			cyc <= cyc + 1;
		end
		if (total_cyc >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$fatal(1, "timeout");
		end
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	function automatic hms_t add_secs(input hms_t t, input int n);
		int   total;
		hms_t r;
		total  = (int'(t.hour) * 3600 + int'(t.min) * 60 + int'(t.sec) + n) % 86400;
		r.hour = 6'(total / 3600);
		r.min  = 6'((total / 60) % 60);
		r.sec  = 6'(total % 60);
		return r;
	endfunction

	// Running time as it stands after edge c
	function automatic hms_t model_time(input int c);
		if (frozen) begin
			return base_time;
		end
		return add_secs(base_time, c / SEC_TICK_DIV - base_tick);
	endfunction

	function automatic logic [5:0] bump(input logic [5:0] v, input int lim);
		return 6'((int'(v) + 1) % (lim + 1));
	endfunction

	// Six {dp, segments} bytes with digit 0 in the low byte
	function automatic logic [NUM_DIGITS-1:0][7:0] ref_frame(input hms_t t, input mode_t m);
		logic [NUM_DIGITS-1:0][7:0] f;
		logic [2:0]                 code;
		logic                       dp;
		int                         val [NUM_DIGITS];
		code   = m;
		val[0] = int'(t.sec) % 10;
		val[1] = int'(t.sec) / 10;
		val[2] = int'(t.min) % 10;
		val[3] = int'(t.min) / 10;
		val[4] = int'(t.hour) % 10;
		val[5] = int'(t.hour) / 10;
		for (int k = 0; k < NUM_DIGITS; k++) begin
			// Only the three lowest digits carry a mode bit
			dp   = (k < 3) ? code[k] : 1'b0;
			f[k] = {dp, DIGIT_SEG[val[k]]};
		end
		return f;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "check failed");
	endtask

	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		if (got !== exp) begin
			fail_now($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_time(input string name, input hms_t got, input hms_t exp);
		if (got !== exp) begin
			fail_now($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// -----------------------------------------------------------------------
	// Compare process for each digit step
	// -----------------------------------------------------------------------
	always @(seg_enb) begin
		int                         k;
		int                         zeros;
		logic [NUM_DIGITS-1:0][7:0] f;
		#0.5;
		if (rst_n === 1'b1) begin
			zeros = 0;
			k = 0;
			for (int i = 0; i < NUM_DIGITS; i++) begin
				if (seg_enb[i] !== 1'b1) begin
					zeros++;
					k = i;
				end
			end
			if (zeros != 1) begin
				fail_now($sformatf("** Error: o_seg_enb got 0x%h expected one low bit", seg_enb));
			end
			if (k != (prev_k + 1) % NUM_DIGITS) begin
				fail_now($sformatf("** Error: o_seg_enb digit got 0x%h expected 0x%h",
					k, (prev_k + 1) % NUM_DIGITS));
			end
			prev_k = k;
			if (check_en) begin
				// Digit was captured from the time before this edge
				f = ref_frame((mode_m == MODE_ALARM) ? alarm_m : model_time(cyc - 1), mode_m);
				check_seg($sformatf("o_seg[%0d]", k), seg, f[k][6:0]);
				check_bit($sformatf("o_seg_dp[%0d]", k), seg_dp, f[k][7]);
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic press_button(input int which);
		check_en = 1'b0;
		for (int v = 1; v >= 0; v--) begin
			case (which)
				BTN_MODE: btn_mode  = 1'(v);
				BTN_POS:  btn_pos   = 1'(v);
				BTN_INC:  btn_inc   = 1'(v);
				default:  btn_alarm = 1'(v);
			endcase
			repeat (BTN_HOLD) next_cycle();
		end
	endtask

	// Mode presses stay clear of a seconds tick
	task automatic step_mode();
		hms_t cur;
		while (cyc % SEC_TICK_DIV < 16 || cyc % SEC_TICK_DIV > SEC_TICK_DIV - PRESS_CYC - 16) begin
			next_cycle();
		end
		cur = model_time(cyc);
		press_button(BTN_MODE);
		if (mode_m == MODE_SETUP) begin
			base_time = cur;
			base_tick = cyc / SEC_TICK_DIV;
			frozen    = 1'b0;
		end
		case (mode_m)
			MODE_CLOCK: mode_m = MODE_SETUP;
			MODE_SETUP: mode_m = MODE_ALARM;
			default:    mode_m = MODE_CLOCK;
		endcase
		if (mode_m == MODE_SETUP) begin
			base_time = cur;
			frozen    = 1'b1;
		end
		check_en = 1'b1;
	endtask

	task automatic step_pos();
		press_button(BTN_POS);
		case (pos_m)
			POS_SEC: pos_m = POS_MIN;
			POS_MIN: pos_m = POS_HOUR;
			default: pos_m = POS_SEC;
		endcase
		check_en = 1'b1;
	endtask

	task automatic inc_times(input int n);
		hms_t t;
		repeat (n) begin
			press_button(BTN_INC);
			t = (mode_m == MODE_ALARM) ? alarm_m : base_time;
			case (pos_m)
				POS_SEC: t.sec  = bump(t.sec, SEC_MAX);
				POS_MIN: t.min  = bump(t.min, SEC_MAX);
				default: t.hour = bump(t.hour, HOUR_MAX);
			endcase
			if (mode_m == MODE_ALARM) begin
				alarm_m = t;
			end else begin
				base_time = t;
			end
			check_en = 1'b1;
		end
	endtask

	// Edits sec, min and hour of the time being set and ends back on seconds
	task automatic set_fields(input hms_t tgt);
		hms_t cur;
		cur = (mode_m == MODE_ALARM) ? alarm_m : base_time;
		inc_times((int'(tgt.sec) - int'(cur.sec) + SEC_MAX + 1) % (SEC_MAX + 1));
		step_pos();
		inc_times((int'(tgt.min) - int'(cur.min) + SEC_MAX + 1) % (SEC_MAX + 1));
		step_pos();
		inc_times((int'(tgt.hour) - int'(cur.hour) + HOUR_MAX + 1) % (HOUR_MAX + 1));
		step_pos();
	endtask

	// Decodes one full frame starting mid-second
	task automatic read_display(output hms_t t);
		int digs [NUM_DIGITS];
		int k;
		while (cyc % SEC_TICK_DIV != SEC_TICK_DIV / 2) begin
			next_cycle();
		end
		repeat (NUM_DIGITS) begin
			@(seg_enb);
			#0.5;
			k = 0;
			for (int i = 0; i < NUM_DIGITS; i++) begin
				if (!seg_enb[i]) begin
					k = i;
				end
			end
			digs[k] = -1;
			for (int d = 0; d < 10; d++) begin
				if (seg == DIGIT_SEG[d]) begin
					digs[k] = d;
				end
			end
			if (digs[k] < 0) begin
				fail_now($sformatf("Digit %0d shows a pattern that is not a number", k));
			end
		end
		t.sec  = 6'(digs[1] * 10 + digs[0]);
		t.min  = 6'(digs[3] * 10 + digs[2]);
		t.hour = 6'(digs[5] * 10 + digs[4]);
		next_cycle();
	endtask

	initial begin
		hms_t t;
		hms_t tgt;
		rst_n     = 1'b0;
		btn_mode  = 1'b0;
		btn_pos   = 1'b0;
		btn_inc   = 1'b0;
		btn_alarm = 1'b0;
		check_en  = 1'b0;
		frozen    = 1'b0;
		base_time = '0;
		base_tick = 0;
		alarm_m   = '0;
		mode_m    = MODE_CLOCK;
		pos_m     = POS_SEC;
		lcg_state = 32'd70;
		repeat (8) @(posedge clk);
		#1;
		rst_n    = 1'b1;
		check_en = 1'b1;

		// Reset state and then free-running time
		check_bit("o_alarm", alarm, 1'b0);
		read_display(t);
		check_time("display", t, '0);
		repeat (3 * SEC_TICK_DIV) next_cycle();
		read_display(t);
		check_time("display", t, model_time(cyc));

		// Random increments per field in SETUP, each count past the wrap
		step_mode();
		inc_times((SEC_MAX + 1) + int'(lcg_next() % ((SEC_MAX + 1) / 2)));
		step_pos();
		inc_times((SEC_MAX + 1) + int'(lcg_next() % ((SEC_MAX + 1) / 2)));
		step_pos();
		inc_times((HOUR_MAX + 1) + int'(lcg_next() % ((HOUR_MAX + 1) / 2)));
		step_pos();

		// Midnight rollover
		tgt = '{hour: 6'd23, min: 6'd59, sec: 6'd58};
		set_fields(tgt);
		step_mode();
		step_mode();
		while (model_time(cyc) != '0) begin
			next_cycle();
		end
		read_display(t);
		check_time("display", t, '0);

		// Alarm ten seconds ahead of the running time
		step_mode();
		step_mode();
		set_fields(add_secs(model_time(cyc), 10));
		read_display(t);
		check_time("alarm display", t, alarm_m);
		step_mode();
		press_button(BTN_ALARM);
		check_en = 1'b1;
		while (model_time(cyc) != alarm_m) begin
			check_bit("o_alarm", alarm, 1'b0);
			next_cycle();
		end
		check_bit("o_alarm", alarm, 1'b0);
		next_cycle();
		check_bit("o_alarm", alarm, 1'b1);
		repeat (2 * SEC_TICK_DIV) next_cycle();
		check_bit("o_alarm", alarm, 1'b1);
		press_button(BTN_ALARM);
		check_en = 1'b1;
		check_bit("o_alarm", alarm, 1'b0);

		$display("test passed");
		$finish;
	end

endmodule

// ==== dv/clock_props.sv ====
/*
 * Concurrent checks on the digit scan and the alarm path, bound into the design.
 */
`timescale 1ns/1ps

module clock_props import clock_pkg::*; (
	input logic                  clk,
	input logic                  rst_n,
	input mode_t                 i_mode,
	input logic                  i_inc,
	input logic                  i_alarm_en,
	input logic                  i_alarm,
	input logic                  i_scan_tick,
	input logic [NUM_DIGITS-1:0] i_seg_enb
);

	logic scan_seen;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_seen <= 1'b0;
		end else if (i_scan_tick) begin
			scan_seen <= 1'b1;
		end
	end

	a_enb_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		scan_seen |-> $onehot(~i_seg_enb))
		else $error("digit enable not one-hot low");

	a_alarm_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(i_alarm) |-> $past(i_alarm_en))
		else $error("alarm rose while disabled");

	a_inc_mode: assert property (@(posedge clk) disable iff (!rst_n)
		i_inc |-> (i_mode != MODE_CLOCK))
		else $error("increment pulse in clock mode");

endmodule

bind display_scan clock_props u_scan_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_mode      (i_mode),
	.i_inc       (1'b0),
	.i_alarm_en  (1'b0),
	.i_alarm     (1'b0),
	.i_scan_tick (scan_tick),
	.i_seg_enb   (o_seg_enb)
);

bind timekeeper clock_props u_keep_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_mode      (keep.mode),
	.i_inc       (keep.inc),
	.i_alarm_en  (keep.alarm_en),
	.i_alarm     (o_alarm),
	.i_scan_tick (1'b0),
	.i_seg_enb   ('1)
);

// ==== design/clock_top.sv ====
/*
 * Top level of the six-digit clock with alarm.
 * Buttons in, multiplexed segment drive and alarm level out.
 */
`timescale 1ns/1ps

module clock_top import clock_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_btn_mode,
	input  logic                  i_btn_pos,
	input  logic                  i_btn_inc,
	input  logic                  i_btn_alarm,
	output seg_t                  o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_alarm
);

	logic sec_tick;
	hms_t disp_time;

	clock_ctrl_if u_ctrl_if ();

	tick_gen #(
		.DIV (SEC_TICK_DIV)
	) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	mode_ctrl u_mode_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (i_btn_mode),
		.i_btn_pos   (i_btn_pos),
		.i_btn_inc   (i_btn_inc),
		.i_btn_alarm (i_btn_alarm),
		.ctrl        (u_ctrl_if)
	);

	timekeeper u_timekeeper (
		.clk         (clk),
		.rst_n       (rst_n),
		.keep        (u_ctrl_if),
		.i_sec_tick  (sec_tick),
		.o_disp_time (disp_time),
		.o_alarm     (o_alarm)
	);

	display_scan u_display_scan (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_time    (disp_time),
		.i_mode    (u_ctrl_if.mode),
		.o_seg     (o_seg),
		.o_seg_dp  (o_seg_dp),
		.o_seg_enb (o_seg_enb)
	);

endmodule

// ==== design/display_scan.sv ====
/*
 * Multiplexed seven-segment driver for six digits.
 * Splits the time into decimal digits and scans one digit per scan tick.
 */
`timescale 1ns/1ps

module display_scan import clock_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  hms_t                  i_time,
	input  mode_t                 i_mode,
	output seg_t                  o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb
);

	localparam int IDX_W = $clog2(NUM_DIGITS);

	logic                  scan_tick;
	logic [IDX_W-1:0]      idx;
	logic [3:0]            digit [NUM_DIGITS];
	logic [NUM_DIGITS-1:0] dp_vec;

	function automatic seg_t seg_of(input logic [3:0] num);
		seg_t seg;
		case (num)
			4'd0:    seg = 7'b111_1110;
			4'd1:    seg = 7'b011_0000;
			4'd2:    seg = 7'b110_1101;
			4'd3:    seg = 7'b111_1001;
			4'd4:    seg = 7'b011_0011;
			4'd5:    seg = 7'b101_1011;
			4'd6:    seg = 7'b101_1111;
			4'd7:    seg = 7'b111_0000;
			4'd8:    seg = 7'b111_1111;
			4'd9:    seg = 7'b111_0011;
			default: seg = 7'b000_0000;
		endcase
		return seg;
	endfunction

	tick_gen #(
		.DIV (SCAN_TICK_DIV)
	) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	// ---------------------------------------------------------------------
	// Digit split, digit 0 is the ones of seconds
	// ---------------------------------------------------------------------
	assign digit[0] = 4'(i_time.sec % 6'd10);
	assign digit[1] = 4'(i_time.sec / 6'd10);
	assign digit[2] = 4'(i_time.min % 6'd10);
	assign digit[3] = 4'(i_time.min / 6'd10);
	assign digit[4] = 4'(i_time.hour % 6'd10);
	assign digit[5] = 4'(i_time.hour / 6'd10);

	// Mode code on the low decimal points, upper ones stay dark
	assign dp_vec = NUM_DIGITS'(i_mode);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx       <= '0;
			o_seg     <= '0;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= '1;
		end else if (scan_tick) begin
			o_seg     <= seg_of(digit[idx]);
			o_seg_dp  <= dp_vec[idx];
			o_seg_enb <= ~(NUM_DIGITS'(1) << idx);
			idx       <= (idx == IDX_W'(NUM_DIGITS - 1)) ? '0 : idx + 1'b1;
		end
	end

endmodule

// ==== design/timekeeper.sv ====
/*
 * Running time and alarm time, with increment routing by mode.
 * Also selects the displayed time and holds the alarm latch.
 */
`timescale 1ns/1ps

module timekeeper import clock_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	clock_ctrl_if.keeper keep,
	input  logic         i_sec_tick,
	output hms_t         o_disp_time,
	output logic         o_alarm
);

	logic run_tick;
	logic time_inc;
	logic alarm_inc;
	hms_t run_time;
	hms_t alarm_time;

	// Time is frozen while it is being set
	assign run_tick  = i_sec_tick && (keep.mode != MODE_SETUP);
	assign time_inc  = keep.inc && (keep.mode == MODE_SETUP);
	assign alarm_inc = keep.inc && (keep.mode == MODE_ALARM);

	hms_counter #(
		.RUNNING (1'b1)
	) u_time (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (run_tick),
		.i_inc  (time_inc),
		.i_pos  (keep.pos),
		.o_time (run_time)
	);

	// Alarm time only moves on presses
	hms_counter #(
		.RUNNING (1'b0)
	) u_alarm_time (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (i_sec_tick),
		.i_inc  (alarm_inc),
		.i_pos  (keep.pos),
		.o_time (alarm_time)
	);

	assign o_disp_time = (keep.mode == MODE_ALARM) ? alarm_time : run_time;

	// Latched on match, cleared only by disabling the alarm
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else if (!keep.alarm_en) begin
			o_alarm <= 1'b0;
		end else if (run_time == alarm_time) begin
			o_alarm <= 1'b1;
		end
	end

endmodule

// ==== design/hms_counter.sv ====
/*
 * Hours:minutes:seconds register with per-field increment.
 * RUNNING adds the seconds tick with its carry chain into minutes and hours.
 */
`timescale 1ns/1ps

module hms_counter import clock_pkg::*; #(
	parameter bit RUNNING = 1'b1
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_tick,
	input  logic i_inc,
	input  pos_t i_pos,
	output hms_t o_time
);

	hms_t time_q;
	hms_t time_nxt;

	function automatic logic [5:0] wrap_inc(input logic [5:0] val, input int lim);
		return (val >= lim) ? 6'd0 : val + 6'd1;
	endfunction

	always_comb begin
		time_nxt = time_q;
		if (i_inc) begin
			// Setting a field never carries into the next one
			case (i_pos)
				POS_SEC:  time_nxt.sec  = wrap_inc(time_q.sec, SEC_MAX);
				POS_MIN:  time_nxt.min  = wrap_inc(time_q.min, SEC_MAX);
				POS_HOUR: time_nxt.hour = wrap_inc(time_q.hour, HOUR_MAX);
				default:  time_nxt      = time_q;
			endcase
		end else if (RUNNING && i_tick) begin
			// Constant RUNNING folds this branch away in the alarm copy
			time_nxt.sec = wrap_inc(time_q.sec, SEC_MAX);
			if (time_q.sec == 6'(SEC_MAX)) begin
				time_nxt.min = wrap_inc(time_q.min, SEC_MAX);
				if (time_q.min == 6'(SEC_MAX)) begin
					time_nxt.hour = wrap_inc(time_q.hour, HOUR_MAX);
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_q <= '0;
		end else begin
			time_q <= time_nxt;
		end
	end

	assign o_time = time_q;

endmodule

// ==== design/mode_ctrl.sv ====
/*
 * Button sampling and press detection, plus the mode, field and alarm-enable state.
 * Drives the control interface toward the timekeeper.
 */
`timescale 1ns/1ps

module mode_ctrl import clock_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_btn_mode,
	input  logic       i_btn_pos,
	input  logic       i_btn_inc,
	input  logic       i_btn_alarm,
	clock_ctrl_if.ctrl ctrl
);

	typedef struct packed {
		logic mode;
		logic pos;
		logic inc;
		logic alarm;
	} btn_t;

	logic  smp_tick;
	logic  smp_d;
	btn_t  btn_raw;
	btn_t  btn_s1;
	btn_t  btn_s2;
	btn_t  press;
	mode_t mode_q;
	pos_t  pos_q;
	logic  alarm_en_q;

	tick_gen #(
		.DIV (BTN_SAMPLE_DIV)
	) u_smp_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (smp_tick)
	);

	assign btn_raw = {i_btn_mode, i_btn_pos, i_btn_inc, i_btn_alarm};

	// ---------------------------------------------------------------------
	// Two-stage sampling at the slow rate filters contact bounce
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp_d  <= 1'b0;
			btn_s1 <= '0;
			btn_s2 <= '0;
		end else begin
			smp_d <= smp_tick;
			if (smp_tick) begin
				btn_s1 <= btn_raw;
				btn_s2 <= btn_s1;
			end
		end
	end

	// Rising sample, valid only in the cycle after a sample tick
	assign press = smp_d ? (btn_s1 & ~btn_s2) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q     <= MODE_CLOCK;
			pos_q      <= POS_SEC;
			alarm_en_q <= 1'b0;
		end else begin
			if (press.mode) begin
				case (mode_q)
					MODE_CLOCK: mode_q <= MODE_SETUP;
					MODE_SETUP: mode_q <= MODE_ALARM;
					default:    mode_q <= MODE_CLOCK;
				endcase
			end
			if (press.pos) begin
				case (pos_q)
					POS_SEC: pos_q <= POS_MIN;
					POS_MIN: pos_q <= POS_HOUR;
					default: pos_q <= POS_SEC;
				endcase
			end
			if (press.alarm) begin
				alarm_en_q <= ~alarm_en_q;
			end
		end
	end

	assign ctrl.mode     = mode_q;
	assign ctrl.pos      = pos_q;
	assign ctrl.alarm_en = alarm_en_q;
	// Increments only mean something while a time is being edited
	assign ctrl.inc      = press.inc && (mode_q != MODE_CLOCK);

endmodule

// ==== design/tick_gen.sv ====
/*
 * Divider giving a one-cycle enable every DIV clocks (DIV >= 2).
 * Replaces derived clocks for seconds, button sampling and the scan.
 */
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = $clog2(DIV);

	logic [CW-1:0] cnt;

	// Terminal count is the tick itself
	assign o_tick = (cnt == CW'(DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (o_tick) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// ==== design/clock_ctrl_if.sv ====
/*
 * Mode and button events from the control block to the timekeeper.
 * inc is a single-cycle pulse per press, the rest are levels.
 */
`timescale 1ns/1ps

interface clock_ctrl_if import clock_pkg::*; ();

	mode_t mode;
	pos_t  pos;
	logic  inc;
	logic  alarm_en;

	modport ctrl (
		output mode,
		output pos,
		output inc,
		output alarm_en
	);

	modport keeper (
		input mode,
		input pos,
		input inc,
		input alarm_en
	);

endinterface

// ==== design/clock_pkg.sv ====
/*
 * Shared types and rate constants of the six-digit clock.
 * RTL and testbench import this package; a board build retunes only the dividers.
 */
package clock_pkg;

	// ---------------------------------------------------------------------
	// Mode and field selector
	// ---------------------------------------------------------------------
	typedef enum logic [2:0] {
		MODE_CLOCK = 3'd0,
		MODE_SETUP = 3'd1,
		MODE_ALARM = 3'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_t;

	// ---------------------------------------------------------------------
	// Time value and display types
	// ---------------------------------------------------------------------
	typedef struct packed {
		logic [5:0] hour;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	// Segments a..g, a in the MSB, active high
	typedef logic [6:0] seg_t;

	localparam int NUM_DIGITS = 6;

	// Wrap limits, minutes share the seconds limit
	localparam int SEC_MAX  = 59;
	localparam int HOUR_MAX = 23;

	// ---------------------------------------------------------------------
	// Tick rates in system clocks (scaled down for simulation)
	// ---------------------------------------------------------------------
	localparam int SEC_TICK_DIV   = 2000;
	localparam int SCAN_TICK_DIV  = 8;
	localparam int BTN_SAMPLE_DIV = 16;

endpackage
